/* source/wb_pipe_pkg.sv */
package wb_pipe_pkg;

  //////////////////////////////////////////////////
  // Data path and register file sizes
  //////////////////////////////////////////////////

  // Width of registers, ALU results and byte addresses
  localparam int XLEN = 32;

  // Three address bits select one of eight architectural registers
  localparam int REG_ADDR_W = 3;

  // Immediates arrive narrow and are sign-extended in the execute stage
  localparam int IMM_W = 16;

  //////////////////////////////////////////////////
  // Data memory geometry
  //////////////////////////////////////////////////

  // Word-addressed data memory inside the load/store unit
  localparam int MEM_WORDS = 64;

  // Word index width, taken from byte address bits 7 to 2
  localparam int MEM_ADDR_W = 6;

  //////////////////////////////////////////////////
  // Instruction opcodes
  //////////////////////////////////////////////////

  // The encoding leaves 3'd7 unused
  typedef enum logic [2:0] {
    OP_NOP   = 3'd0,
    OP_ADD   = 3'd1,
    OP_SUB   = 3'd2,
    OP_XOR   = 3'd3,
    OP_ADDI  = 3'd4,
    OP_LOAD  = 3'd5,
    OP_STORE = 3'd6
  } op_e;

  //////////////////////////////////////////////////
  // Load/store unit FSM
  //////////////////////////////////////////////////

  // Idle covers zero-wait accesses, wait covers the slower ones
  typedef enum logic {
    LSU_IDLE = 1'b0,
    LSU_WAIT = 1'b1
  } lsu_state_e;

endpackage

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file import wb_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,

  // Two combinational read ports for the execute stage
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,

  // Single write port driven by the write-back stage
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  // One entry per architectural register
  logic [XLEN-1:0] regs_q [2**REG_ADDR_W];

  // All registers come out of reset as zero
  // Register 0 is never written so it keeps that value
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value during a write
  // The execute stage bypasses the write port itself
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* source/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage import wb_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,

  // Instruction port
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  op_e                   instr_op_i,
  input  logic [REG_ADDR_W-1:0] instr_rd_i,
  input  logic [REG_ADDR_W-1:0] instr_rs1_i,
  input  logic [REG_ADDR_W-1:0] instr_rs2_i,
  input  logic [IMM_W-1:0]      instr_imm_i,

  // Register file read ports
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,

  // Register file write port, observed for bypassing
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       rf_wdata_i,

  // EX/WB pipe register and its handshake
  input  logic                  wb_ready_i,
  output logic                  wb_instr_valid_o,
  output op_e                   wb_op_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic                  wb_rf_we_o,
  output logic [XLEN-1:0]       wb_result_o,
  output logic [XLEN-1:0]       wb_addr_o
);

  // Accept register contents
  logic                  acc_valid;
  op_e                   acc_op;
  logic [REG_ADDR_W-1:0] acc_rd;
  logic [REG_ADDR_W-1:0] acc_rs1;
  logic [REG_ADDR_W-1:0] acc_rs2;
  logic [IMM_W-1:0]      acc_imm;

  logic                  use_rs1;
  logic                  use_rs2;
  logic                  ex_fwd_ok;
  logic                  load_pending;
  logic                  load_use;
  logic                  ex_wb_free;
  logic                  acc_advance;
  logic                  acc_rf_we;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  logic [XLEN-1:0]       imm_ext;
  logic [XLEN-1:0]       mem_addr;
  logic [XLEN-1:0]       alu_result;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // The EX/WB register can take a new entry when it is empty or retiring
  assign ex_wb_free    = !wb_instr_valid_o || wb_ready_i;
  assign acc_advance   = acc_valid && ex_wb_free && !load_use;
  assign instr_ready_o = !acc_valid || acc_advance;

  // Accept register, filled straight from the instruction port
  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc_valid <= 1'b0;
    end else if (instr_ready_o) begin
      acc_valid <= instr_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid_i && instr_ready_o) begin
      acc_op  <= instr_op_i;
      acc_rd  <= instr_rd_i;
      acc_rs1 <= instr_rs1_i;
      acc_rs2 <= instr_rs2_i;
      acc_imm <= instr_imm_i;
    end
  end

  //////////////////////////////////////////////////
  // Operand read, bypass and interlock
  //////////////////////////////////////////////////

  assign rs1_addr_o = acc_rs1;
  assign rs2_addr_o = acc_rs2;

  // No-op reads nothing and only register-register ops and stores read rs2
  assign use_rs1 = (acc_op != OP_NOP);
  assign use_rs2 = (acc_op == OP_ADD) || (acc_op == OP_SUB) || (acc_op == OP_XOR) ||
                   (acc_op == OP_STORE);

  // A non-load in EX/WB already holds its final value
  assign ex_fwd_ok = wb_instr_valid_o && wb_rf_we_o && (wb_op_o != OP_LOAD);

  // Newest value wins, the EX/WB entry first and then the write in progress
  assign op_a = (ex_fwd_ok && (wb_rd_o == acc_rs1))     ? wb_result_o :
                (rf_we_i && (rf_waddr_i == acc_rs1))    ? rf_wdata_i  :
                                                          rs1_data_i;
  assign op_b = (ex_fwd_ok && (wb_rd_o == acc_rs2))     ? wb_result_o :
                (rf_we_i && (rf_waddr_i == acc_rs2))    ? rf_wdata_i  :
                                                          rs2_data_i;

  // Load data only exists on the write port in the cycle the load retires
  // Until then a consumer of its rd must stay in the accept register
  assign load_pending = wb_instr_valid_o && wb_rf_we_o && (wb_op_o == OP_LOAD);
  assign load_use     = acc_valid && load_pending && !wb_ready_i &&
                        ((use_rs1 && (acc_rs1 == wb_rd_o)) ||
                         (use_rs2 && (acc_rs2 == wb_rd_o)));

  //////////////////////////////////////////////////
  // ALU and address generation
  //////////////////////////////////////////////////

  assign imm_ext  = {{(XLEN-IMM_W){acc_imm[IMM_W-1]}}, acc_imm};
  assign mem_addr = op_a + imm_ext;

  always_comb begin
    case (acc_op)
      OP_ADD:   alu_result = op_a + op_b;
      OP_SUB:   alu_result = op_a - op_b;
      OP_XOR:   alu_result = op_a ^ op_b;
      OP_ADDI:  alu_result = mem_addr;
      // Store data travels in the result field
      OP_STORE: alu_result = op_b;
      default:  alu_result = '0;
    endcase
  end

  // Only stores and no-ops leave the register file alone
  assign acc_rf_we = (acc_op != OP_STORE) && (acc_op != OP_NOP) && (acc_rd != '0);

  //////////////////////////////////////////////////
  // EX/WB pipe register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_instr_valid_o <= 1'b0;
      wb_op_o          <= OP_NOP;
      wb_rf_we_o       <= 1'b0;
    end else if (ex_wb_free) begin
      wb_instr_valid_o <= acc_advance;
      if (acc_advance) begin
        wb_op_o    <= acc_op;
        wb_rf_we_o <= acc_rf_we;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_advance) begin
      wb_rd_o     <= acc_rd;
      wb_result_o <= alu_result;
      wb_addr_o   <= mem_addr;
    end
  end

endmodule

/* source/lsu.sv */
`timescale 1ns/100ps

module lsu import wb_pipe_pkg::*; (
  input  logic            clk,
  input  logic            rst_i,

  // Request, taken from the EX/WB pipe register
  input  logic            valid_i,
  input  op_e             op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,

  // Response towards the write-back stage
  output logic            rvalid_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            fault_o
);

  lsu_state_e            state_q;
  lsu_state_e            state_d;
  logic [1:0]            wait_cnt_q;
  logic [1:0]            wait_target;
  logic                  wait_done;
  logic                  access;
  logic                  in_range;
  logic [MEM_ADDR_W-1:0] word_idx;

  // Data memory, word addressed
  logic [XLEN-1:0]       mem_q [MEM_WORDS];

  //////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////

  // Only loads and stores sitting in EX/WB are requests
  assign access = valid_i && ((op_i == OP_LOAD) || (op_i == OP_STORE));

  // Unsigned compare, so negative addresses also land out of range
  assign in_range = (addr_i < XLEN'(MEM_WORDS * 4));

  assign word_idx    = addr_i[MEM_ADDR_W+1:2];
  assign wait_target = addr_i[3:2];

  // Faults are reported in the first cycle and never wait
  assign fault_o = access && !in_range;

  //////////////////////////////////////////////////
  // Response timing
  //////////////////////////////////////////////////

  // In idle the access is in its first cycle, in wait the counter holds the cycles spent
  always_comb begin
    case (state_q)
      LSU_WAIT: wait_done = (wait_cnt_q == wait_target);
      default:  wait_done = (wait_target == 2'd0);
    endcase
  end

  assign rvalid_o = access && in_range && wait_done;
  assign rdata_o  = mem_q[word_idx];

  // Write-back always accepts on rvalid or fault, so both end the access
  always_comb begin
    state_d = state_q;
    if (rvalid_o || fault_o) begin
      state_d = LSU_IDLE;
    end else if (access) begin
      state_d = LSU_WAIT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= LSU_IDLE;
      wait_cnt_q <= 2'd0;
    end else begin
      state_q <= state_d;
      // Count wait cycles and clear once the access ends
      if (state_d == LSU_WAIT) begin
        wait_cnt_q <= wait_cnt_q + 2'd1;
      end else begin
        wait_cnt_q <= 2'd0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Memory write
  //////////////////////////////////////////////////

  // Stores commit on their rvalid cycle, and faulting stores never reach here
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (rvalid_o && (op_i == OP_STORE)) begin
      mem_q[word_idx] <= wdata_i;
    end
  end

endmodule

/* source/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage import wb_pipe_pkg::*; (
  // EX/WB pipe register
  input  logic                  instr_valid_i,
  input  op_e                   op_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  rf_we_i,
  input  logic [XLEN-1:0]       result_i,

  // Load/store unit response
  input  logic                  lsu_rvalid_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_fault_i,

  // Register file write port
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,

  // Stage handshake and retirement status
  output logic                  ready_o,
  output logic                  valid_o,
  output logic                  fault_o,
  output logic                  data_stall_o
);

  logic is_mem;
  logic is_load;
  logic lsu_done;

  assign is_load = (op_i == OP_LOAD);
  assign is_mem  = is_load || (op_i == OP_STORE);

  // A memory access ends with either data or a fault
  assign lsu_done = lsu_rvalid_i || lsu_fault_i;

  //////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////

  // A faulting access never writes, and a load writes only with its data
  assign rf_we_o    = instr_valid_i && rf_we_i && !lsu_fault_i &&
                      (!is_load || lsu_rvalid_i);
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = is_load ? lsu_rdata_i : result_i;

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  // This is the last stage, so retiring and accepting the next entry coincide
  assign valid_o = instr_valid_i && (!is_mem || lsu_done);
  assign ready_o = !instr_valid_i || !is_mem || lsu_done;

  assign fault_o = instr_valid_i && is_mem && lsu_fault_i;

  // Stall while a load or store still waits on the memory
  assign data_stall_o = instr_valid_i && is_mem && !lsu_done;

endmodule

/* source/wb_pipe_top.sv */
`timescale 1ns/100ps

module wb_pipe_top import wb_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,

  // Instruction port
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  op_e                   instr_op_i,
  input  logic [REG_ADDR_W-1:0] instr_rd_i,
  input  logic [REG_ADDR_W-1:0] instr_rs1_i,
  input  logic [REG_ADDR_W-1:0] instr_rs2_i,
  input  logic [IMM_W-1:0]      instr_imm_i,

  // Retirement report
  output logic                  retire_valid_o,
  output logic [REG_ADDR_W-1:0] retire_rd_o,
  output logic                  retire_we_o,
  output logic [XLEN-1:0]       retire_data_o,
  output logic                  retire_fault_o,
  output logic                  data_stall_o
);

  // Register file read
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  // Register file write from write-back
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  // EX/WB pipe register
  logic                  wb_instr_valid;
  op_e                   wb_op;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic                  wb_rf_we;
  logic [XLEN-1:0]       wb_result;
  logic [XLEN-1:0]       wb_addr;
  logic                  wb_ready;

  // Load/store unit response
  logic                  lsu_rvalid;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  lsu_fault;

  register_file u_register_file (
    .clk       (clk),
    .rst_i     (rst_i),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  ex_stage u_ex_stage (
    .clk              (clk),
    .rst_i            (rst_i),
    .instr_valid_i    (instr_valid_i),
    .instr_ready_o    (instr_ready_o),
    .instr_op_i       (instr_op_i),
    .instr_rd_i       (instr_rd_i),
    .instr_rs1_i      (instr_rs1_i),
    .instr_rs2_i      (instr_rs2_i),
    .instr_imm_i      (instr_imm_i),
    .rs1_addr_o       (rs1_addr),
    .rs2_addr_o       (rs2_addr),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .rf_we_i          (rf_we),
    .rf_waddr_i       (rf_waddr),
    .rf_wdata_i       (rf_wdata),
    .wb_ready_i       (wb_ready),
    .wb_instr_valid_o (wb_instr_valid),
    .wb_op_o          (wb_op),
    .wb_rd_o          (wb_rd),
    .wb_rf_we_o       (wb_rf_we),
    .wb_result_o      (wb_result),
    .wb_addr_o        (wb_addr)
  );

  // The LSU sees the EX/WB entry directly and filters for loads and stores
  lsu u_lsu (
    .clk      (clk),
    .rst_i    (rst_i),
    .valid_i  (wb_instr_valid),
    .op_i     (wb_op),
    .addr_i   (wb_addr),
    .wdata_i  (wb_result),
    .rvalid_o (lsu_rvalid),
    .rdata_o  (lsu_rdata),
    .fault_o  (lsu_fault)
  );

  wb_stage u_wb_stage (
    .instr_valid_i (wb_instr_valid),
    .op_i          (wb_op),
    .rd_i          (wb_rd),
    .rf_we_i       (wb_rf_we),
    .result_i      (wb_result),
    .lsu_rvalid_i  (lsu_rvalid),
    .lsu_rdata_i   (lsu_rdata),
    .lsu_fault_i   (lsu_fault),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .ready_o       (wb_ready),
    .valid_o       (retire_valid_o),
    .fault_o       (retire_fault_o),
    .data_stall_o  (data_stall_o)
  );

  // The retirement report mirrors the register file write port
  assign retire_rd_o   = rf_waddr;
  assign retire_we_o   = rf_we;
  assign retire_data_o = rf_wdata;

endmodule

/* tests/wb_pipe_checker.sv */
`timescale 1ns/100ps

module wb_pipe_checker import wb_pipe_pkg::*; (
  input logic clk,
  input logic rst_i,

  // Write-back stage inputs from the EX/WB register
  input logic instr_valid_i,
  input op_e  op_i,

  // Write-back stage outputs
  input logic rf_we_i,
  input logic ready_i,
  input logic valid_i,
  input logic fault_i,
  input logic data_stall_i
);

  // A faulting access retires without touching the register file
  no_write_on_fault: assert property (
    @(posedge clk) disable iff (rst_i) fault_i |-> !rf_we_i
  ) else $error("register file written while the access faulted");

  // Only a load or store can hold the stage waiting on memory
  stall_only_for_mem: assert property (
    @(posedge clk) disable iff (rst_i)
    data_stall_i |-> instr_valid_i && ((op_i == OP_LOAD) || (op_i == OP_STORE))
  ) else $error("data stall raised without a load or store in write-back");

  // Last stage, so accepting the next entry and retiring this one coincide
  ready_tracks_valid: assert property (
    @(posedge clk) disable iff (rst_i) instr_valid_i |-> (ready_i == valid_i)
  ) else $error("write-back ready and valid differ while an instruction is present");

endmodule

// The write-back stage is purely combinational and has no clock port
// Its nets and the clock all meet in the top level, so the checker sits there
bind wb_pipe_top wb_pipe_checker u_wb_checker (
  .clk           (clk),
  .rst_i         (rst_i),
  .instr_valid_i (wb_instr_valid),
  .op_i          (wb_op),
  .rf_we_i       (rf_we),
  .ready_i       (wb_ready),
  .valid_i       (retire_valid_o),
  .fault_i       (retire_fault_o),
  .data_stall_i  (data_stall_o)
);

/* tests/wb_pipe_tb.sv */
`timescale 1ns/100ps

module wb_pipe_tb import wb_pipe_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int N_ALU        = 300;
  // Iterations of the memory, fault and register 0 tests, four, four and three instructions
  localparam int N_MEM_ITER   = 40;
  localparam int N_FAULT_ITER = 20;
  localparam int N_ZERO_ITER  = 10;
  localparam int N_MIX        = 200;
  localparam int N_TOTAL      = N_ALU + 4 * N_MEM_ITER + 4 * N_FAULT_ITER +
                                3 * N_ZERO_ITER + N_MIX;
  localparam int CYCLE_LIMIT  = 20 * N_TOTAL + 200;

  logic                  clk;
  logic                  rst;
  logic                  instr_valid;
  logic                  instr_ready;
  op_e                   instr_op;
  logic [REG_ADDR_W-1:0] instr_rd;
  logic [REG_ADDR_W-1:0] instr_rs1;
  logic [REG_ADDR_W-1:0] instr_rs2;
  logic [IMM_W-1:0]      instr_imm;
  logic                  retire_valid;
  logic [REG_ADDR_W-1:0] retire_rd;
  logic                  retire_we;
  logic [XLEN-1:0]       retire_data;
  logic                  retire_fault;
  logic                  data_stall;

  // Reference model state and the expected retirements in program order
  logic [XLEN-1:0]       model_regs [2**REG_ADDR_W];
  logic [XLEN-1:0]       model_mem [MEM_WORDS];
  logic [REG_ADDR_W-1:0] exp_rd_q [$];
  logic                  exp_we_q [$];
  logic [XLEN-1:0]       exp_data_q [$];
  logic                  exp_fault_q [$];
  logic                  exp_mem_q [$];

  logic [31:0] rng;
  int          errors;
  int          checks;
  int          accepted;
  int          retired;
  int          cycle_cnt;

  wb_pipe_top dut_i (
    .clk            (clk),
    .rst_i          (rst),
    .instr_valid_i  (instr_valid),
    .instr_ready_o  (instr_ready),
    .instr_op_i     (instr_op),
    .instr_rd_i     (instr_rd),
    .instr_rs1_i    (instr_rs1),
    .instr_rs2_i    (instr_rs2),
    .instr_imm_i    (instr_imm),
    .retire_valid_o (retire_valid),
    .retire_rd_o    (retire_rd),
    .retire_we_o    (retire_we),
    .retire_data_o  (retire_data),
    .retire_fault_o (retire_fault),
    .data_stall_o   (data_stall)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic op_e pick_alu_op(input logic [1:0] sel);
    case (sel)
      2'd0:    return OP_ADD;
      2'd1:    return OP_SUB;
      2'd2:    return OP_XOR;
      default: return OP_ADDI;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Applies one instruction to the model and queues what it must retire with
  task automatic model_step(input op_e op, input logic [REG_ADDR_W-1:0] rd,
                            input logic [REG_ADDR_W-1:0] rs1,
                            input logic [REG_ADDR_W-1:0] rs2,
                            input logic [IMM_W-1:0] imm);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] res;
    logic            we;
    logic            fault;
    logic            mem;
    logic            bad_addr;
    a        = model_regs[rs1];
    b        = model_regs[rs2];
    addr     = a + {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    // Negative or at least 256 bytes is outside the 64-word memory
    bad_addr = addr[XLEN-1] || (addr >= 256);
    res      = '0;
    we       = 1'b0;
    fault    = 1'b0;
    mem      = 1'b0;
    case (op)
      OP_ADD: begin
        res = a + b;
        we  = 1'b1;
      end
      OP_SUB: begin
        res = a - b;
        we  = 1'b1;
      end
      OP_XOR: begin
        res = a ^ b;
        we  = 1'b1;
      end
      OP_ADDI: begin
        res = addr;
        we  = 1'b1;
      end
      OP_LOAD: begin
        mem   = 1'b1;
        fault = bad_addr;
        we    = !bad_addr;
        res   = model_mem[addr[7:2]];
      end
      OP_STORE: begin
        mem   = 1'b1;
        fault = bad_addr;
        if (!bad_addr) model_mem[addr[7:2]] = b;
      end
      default: ;
    endcase
    if (rd == '0) we = 1'b0;
    if (we) model_regs[rd] = res;
    exp_rd_q.push_back(rd);
    exp_we_q.push_back(we);
    exp_data_q.push_back(res);
    exp_fault_q.push_back(fault);
    exp_mem_q.push_back(mem);
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic issue(input op_e op, input logic [REG_ADDR_W-1:0] rd,
                       input logic [REG_ADDR_W-1:0] rs1,
                       input logic [REG_ADDR_W-1:0] rs2,
                       input logic [IMM_W-1:0] imm);
    model_step(op, rd, rs1, rs2, imm);
    instr_valid = 1'b1;
    instr_op    = op;
    instr_rd    = rd;
    instr_rs1   = rs1;
    instr_rs2   = rs2;
    instr_imm   = imm;
    // Ready only moves on the rising edge, so its mid-cycle value decides the transfer
    while (!instr_ready) @(negedge clk);
    @(negedge clk);
    accepted++;
  endtask

  task automatic idle(input int cycles);
    instr_valid = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  // Waits for all outstanding retirements, then a few quiet cycles to catch duplicates
  task automatic drain();
    instr_valid = 1'b0;
    while (exp_we_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic report_test(input int num, input string name, input int n_instr,
                             input int err_before);
    $display("test %0d %s: %0d instructions, %0d errors", num, name, n_instr,
             errors - err_before);
  endtask

  //////////////////////////////////////////////////
  // Retirement monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst) begin
      if (data_stall) begin
        checks++;
        assert ((exp_mem_q.size() != 0) && exp_mem_q[0]) else begin
          errors++;
          $display("Data stall at t=%0t while no load or store was waiting", $time);
        end
      end
      if (retire_valid) begin
        checks++;
        // Every retirement the DUT reports is counted, expected or not
        retired++;
        assert (exp_we_q.size() != 0) else begin
          errors++;
          $display("Retirement at t=%0t with no instruction outstanding", $time);
        end
        if (exp_we_q.size() != 0) begin
          check_value("retire_we_o", exp_we_q[0], retire_we);
          check_value("retire_fault_o", exp_fault_q[0], retire_fault);
          // Destination and data only matter when the register file is written
          if (exp_we_q[0]) begin
            check_value("retire_rd_o", exp_rd_q[0], retire_rd);
            check_value("retire_data_o", exp_data_q[0], retire_data);
          end
          void'(exp_rd_q.pop_front());
          void'(exp_we_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_fault_q.pop_front());
          void'(exp_mem_q.pop_front());
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int                    err_before;
    logic [31:0]           r;
    logic [REG_ADDR_W-1:0] prev_rd;
    logic [REG_ADDR_W-1:0] ra;
    logic [REG_ADDR_W-1:0] rb;
    logic [REG_ADDR_W-1:0] rc;
    logic [REG_ADDR_W-1:0] rx;
    logic [IMM_W-1:0]      base;
    logic [IMM_W-1:0]      bad_imm;
    op_e                   op;
    rng         = 32'h317a;
    errors      = 0;
    checks      = 0;
    accepted    = 0;
    retired     = 0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr_op    = OP_NOP;
    instr_rd    = '0;
    instr_rs1   = '0;
    instr_rs2   = '0;
    instr_imm   = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    foreach (model_mem[i]) model_mem[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Test 1, idle state straight after reset
    err_before = errors;
    check_value("retire_valid_o", 1'b0, retire_valid);
    check_value("retire_we_o", 1'b0, retire_we);
    check_value("retire_fault_o", 1'b0, retire_fault);
    check_value("data_stall_o", 1'b0, data_stall);
    check_value("instr_ready_o", 1'b1, instr_ready);
    report_test(1, "reset", 0, err_before);

    // Test 2, back-to-back ALU ops where sources often name the previous rd
    err_before = errors;
    prev_rd    = 3'd1;
    for (int i = 0; i < N_ALU; i++) begin
      r  = next_rand();
      ra = 1 + r[2:0] % 7;
      rb = r[3] ? prev_rd : r[6:4];
      rc = r[7] ? prev_rd : r[10:8];
      issue(pick_alu_op(r[12:11]), ra, rb, rc, r[31:16]);
      prev_rd = ra;
    end
    drain();
    report_test(2, "alu_stream", N_ALU, err_before);

    // Test 3, store through a fresh base register, load, then use the load at once
    err_before = errors;
    for (int i = 0; i < N_MEM_ITER; i++) begin
      r    = next_rand();
      base = {8'd0, r[5:0], 2'b00};
      ra   = 1 + r[8:6] % 7;
      rb   = r[11:9];
      rc   = 1 + r[14:12] % 7;
      rx   = 1 + r[17:15] % 7;
      issue(OP_ADDI, ra, 3'd0, 3'd0, base);
      issue(OP_STORE, 3'd0, ra, rb, '0);
      issue(OP_LOAD, rc, 3'd0, 3'd0, r[18] ? base : {8'd0, r[24:19], 2'b00});
      issue(OP_ADD, rx, rc, rc, '0);
    end
    drain();
    report_test(3, "store_load", 4 * N_MEM_ITER, err_before);

    // Test 4, faulting accesses above the memory or at negative addresses
    err_before = errors;
    for (int i = 0; i < N_FAULT_ITER; i++) begin
      r       = next_rand();
      bad_imm = r[0] ? ({2'b00, r[13:2], 2'b00} | 16'h0100) : {1'b1, r[15:1]};
      ra      = 1 + r[18:16] % 7;
      rb      = r[21:19];
      rx      = 1 + r[24:22] % 7;
      issue(OP_LOAD, ra, 3'd0, 3'd0, bad_imm);
      issue(OP_STORE, 3'd0, 3'd0, rb, bad_imm);
      // Read back the register the load targeted and the word the address aliases
      issue(OP_ADD, rx, ra, 3'd0, '0);
      issue(OP_LOAD, rx, 3'd0, 3'd0, {8'd0, bad_imm[7:2], 2'b00});
    end
    drain();
    report_test(4, "access_fault", 4 * N_FAULT_ITER, err_before);

    // Test 5, writes aimed at register 0 and reads of it afterwards
    err_before = errors;
    for (int i = 0; i < N_ZERO_ITER; i++) begin
      r = next_rand();
      issue(OP_ADDI, 3'd0, r[2:0], 3'd0, r[31:16]);
      issue(OP_LOAD, 3'd0, 3'd0, 3'd0, {8'd0, r[8:3], 2'b00});
      issue(OP_ADD, 1 + r[11:9] % 7, 3'd0, 3'd0, '0);
    end
    drain();
    report_test(5, "register_zero", 3 * N_ZERO_ITER, err_before);

    // Test 6, every kind of instruction with idle gaps in between
    err_before = errors;
    for (int i = 0; i < N_MIX; i++) begin
      r  = next_rand();
      op = op_e'(r[2:0] % 7);
      ra = r[5:3];
      rb = r[8:6];
      base = r[31:16];
      if ((op == OP_LOAD) || (op == OP_STORE)) begin
        // Mostly in range from register 0, now and then a negative address
        rb   = 3'd0;
        base = (r[12] && r[13]) ? {1'b1, r[30:16]} : {8'd0, r[21:16], 2'b00};
      end
      issue(op, ra, rb, r[11:9], base);
      if (r[15:14] == 2'b00) idle(1 + r[24:23]);
    end
    drain();
    report_test(6, "random_mix", N_MIX, err_before);

    checks++;
    assert ((accepted == retired) && (accepted == N_TOTAL)) else begin
      errors++;
      $display("Issued %0d, accepted %0d and retired %0d instructions do not agree",
               N_TOTAL, accepted, retired);
    end
    $display("Done: %0d checks, %0d errors, %0d accepted, %0d retired",
             checks, errors, accepted, retired);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* wb_pipe.f */
source/wb_pipe_pkg.sv
source/register_file.sv
source/ex_stage.sv
source/lsu.sv
source/wb_stage.sv
source/wb_pipe_top.sv
tests/wb_pipe_checker.sv
tests/wb_pipe_tb.sv
